// File: unet_dec.f
logic/dec_cfg_pkg.sv
logic/dec_bus_pkg.sv
logic/feature_ram.sv
logic/tap_fetch.sv
logic/conv_engine.sv
logic/dec_regs.sv
logic/unet_dec_top.sv
tb/unet_dec_props.sv
tb/unet_dec_checker.sv
tb/unet_dec_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := unet_dec_tb
FILELIST  := unet_dec.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/unet_dec_tb.sv
/* Decoder stage testbench */
`timescale 1ns/1ps

module unet_dec_tb;

    logic                 clk;
    logic                 rst;
    dec_bus_pkg::wb_req_t wb_req;
    dec_bus_pkg::wb_rsp_t wb_rsp;
    int                   n_checks;
    int                   n_errors;
    int                   bus_errors;
    int                   err_mark;
    int                   test_num;
    logic [31:0]          lcg_state;

    unet_dec_top dut0 (
        .clk(clk),
        .rst(rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    unet_dec_checker chk0 (
        .clk(clk),
        .rst(rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .checks(n_checks),
        .errors(n_errors)
    );

    always #2 clk = ~clk;

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[31:16]);
    endfunction

    // One Wishbone classic access, held until ack
    task automatic bus_cycle(input logic we, input int adr, input int wdat,
                             output logic [15:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr[dec_bus_pkg::ADR_W-1:0];
        wb_req.dat_w = wdat[dec_bus_pkg::DAT_W-1:0];
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < 8);
        if (!wb_rsp.ack) begin
            $display("Bus access to address 0x%03h was never acknowledged", adr);
            bus_errors++;
            rdat = '0;
        end else begin
            rdat = wb_rsp.dat_r;
        end
        #1;
        wb_req = '0;
    endtask

    task automatic bus_write(input int adr, input int dat);
        logic [15:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input int adr, output logic [15:0] dat);
        bus_cycle(1'b0, adr, 0, dat);
    endtask

    // 0 random, 1 all ones, 2 random non-negative
    function automatic int feat_value(input int mode);
        case (mode)
            1: return 1;
            2: return next_rand() & 32'h7fff;
            default: return next_rand();
        endcase
    endfunction

    task automatic load_features(input int mode);
        for (int i = 0; i < dec_cfg_pkg::IN_WORDS; i++) begin
            bus_write(int'(dec_bus_pkg::IN_BASE) + i, feat_value(mode));
        end
        for (int i = 0; i < dec_cfg_pkg::SKIP_WORDS; i++) begin
            bus_write(int'(dec_bus_pkg::SKIP_BASE) + i, feat_value(mode));
        end
    endtask

    // 0 random, 1 zero, 2 all ones, 3 a single 1 on the centre tap of channel sel
    task automatic load_weights(input int mode, input int sel, input int bias0, input int bias1);
        int w;
        int ic;
        int tap;
        for (int i = 0; i < dec_cfg_pkg::BIAS_BASE; i++) begin
            ic  = i / (dec_cfg_pkg::KTAPS * dec_cfg_pkg::OUT_CH);
            tap = (i / dec_cfg_pkg::OUT_CH) % dec_cfg_pkg::KTAPS;
            case (mode)
                1: w = 0;
                2: w = 1;
                3: w = (ic == sel && tap == dec_cfg_pkg::KTAPS / 2) ? 1 : 0;
                default: w = next_rand() & 32'hff;
            endcase
            bus_write(int'(dec_bus_pkg::WGT_BASE) + i, w);
        end
        bus_write(int'(dec_bus_pkg::WGT_BASE) + dec_cfg_pkg::BIAS_BASE, bias0 & 32'hff);
        bus_write(int'(dec_bus_pkg::WGT_BASE) + dec_cfg_pkg::BIAS_BASE + 1, bias1 & 32'hff);
    endtask

    task automatic wait_done();
        logic [15:0] status;
        status = '0;
        while (!status[dec_bus_pkg::STAT_DONE]) begin
            bus_read(int'(dec_bus_pkg::ADR_STATUS), status);
        end
    endtask

    task automatic read_outputs();
        logic [15:0] d;
        for (int i = 0; i < dec_cfg_pkg::OUT_WORDS; i++) begin
            bus_read(int'(dec_bus_pkg::OUT_BASE) + i, d);
        end
    endtask

    task automatic run_stage();
        bus_write(int'(dec_bus_pkg::ADR_CTRL), 1 << dec_bus_pkg::CTRL_START);
        wait_done();
        read_outputs();
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = n_errors + bus_errors;
        test_num++;
        if (errs == err_mark) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errs - err_mark);
        end
        err_mark = errs;
    endtask

    initial begin
        logic [15:0] d;
        clk        = 1'b0;
        rst        = 1'b1;
        wb_req     = '0;
        lcg_state  = 32'd71;
        bus_errors = 0;
        err_mark   = 0;
        test_num   = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        bus_read(int'(dec_bus_pkg::ADR_STATUS), d);
        bus_read(int'(dec_bus_pkg::ADR_CTRL), d);
        bus_write(32'h020, 32'hbeef);
        bus_read(32'h020, d);
        finish_test("reset state");

        load_features(0);
        load_weights(0, 0, next_rand(), next_rand());
        run_stage();
        finish_test("random data");

        load_weights(1, 0, 37, -5);
        run_stage();
        finish_test("bias and ReLU");

        // Upsampled channel 1, then skip channel 1
        load_features(2);
        load_weights(3, 1, 0, 0);
        run_stage();
        load_weights(3, 3, 0, 0);
        run_stage();
        finish_test("upsample and concat");

        load_features(1);
        load_weights(2, 0, 0, 0);
        run_stage();
        finish_test("border padding");

        // Second start lands while the first run is busy
        load_features(0);
        load_weights(0, 0, next_rand(), next_rand());
        bus_write(int'(dec_bus_pkg::ADR_CTRL), 1);
        bus_read(int'(dec_bus_pkg::ADR_STATUS), d);
        bus_write(int'(dec_bus_pkg::ADR_CTRL), 1);
        wait_done();
        bus_read(int'(dec_bus_pkg::ADR_STATUS), d);
        read_outputs();
        load_features(0);
        load_weights(0, 0, next_rand(), next_rand());
        run_stage();
        finish_test("restart and rerun");

        $display("%0d checks, %0d errors, %0d assertion failures",
                 n_checks, n_errors + bus_errors, dut0.u_regs.props0.fail_count);
        if (n_errors == 0 && bus_errors == 0 && dut0.u_regs.props0.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Six tests of up to two runs each, margin of three
    initial begin
        int run_cycles;
        int bus_cycles;
        int limit_ns;
        run_cycles = dec_cfg_pkg::OUT_WORDS * (dec_cfg_pkg::CAT_CH * dec_cfg_pkg::KTAPS + 4);
        bus_cycles = 3 * (dec_cfg_pkg::IN_WORDS + dec_cfg_pkg::SKIP_WORDS
                          + dec_cfg_pkg::WGT_WORDS + dec_cfg_pkg::OUT_WORDS);
        limit_ns   = 6 * 2 * (run_cycles + bus_cycles) * 3 * 4;
        #(limit_ns);
        $display("Timeout: the tests did not complete within %0d ns", limit_ns);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: tb/unet_dec_checker.sv
/* Decoder stage reference and readback checker */
`timescale 1ns/1ps

module unet_dec_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  dec_bus_pkg::wb_req_t wb_req,
    input  dec_bus_pkg::wb_rsp_t wb_rsp,
    output int                   checks,
    output int                   errors
);

    // Shadow copies of what the host loaded
    dec_cfg_pkg::feat_t in_mem   [dec_cfg_pkg::IN_WORDS];
    dec_cfg_pkg::feat_t skip_mem [dec_cfg_pkg::SKIP_WORDS];
    dec_cfg_pkg::wgt_t  wgt_mem  [dec_cfg_pkg::WGT_WORDS];

    // Expected status sequencing
    logic running;
    logic done_m;
    logic await_busy;

    function automatic logic in_window(input int ofs, input logic [8:0] base, input int words);
        return ofs >= int'(base) && ofs < int'(base) + words;
    endfunction

    function automatic logic [15:0] expected_out(input int idx);
        int oc;
        int h;
        int w;
        int ih;
        int iw;
        int f;
        int acc;
        oc  = idx / (dec_cfg_pkg::UP_W * dec_cfg_pkg::UP_H);
        h   = (idx / dec_cfg_pkg::UP_W) % dec_cfg_pkg::UP_H;
        w   = idx % dec_cfg_pkg::UP_W;
        acc = int'(wgt_mem[dec_cfg_pkg::BIAS_BASE + oc]);
        for (int ic = 0; ic < dec_cfg_pkg::CAT_CH; ic++) begin
            for (int kh = 0; kh < dec_cfg_pkg::KSIZE; kh++) begin
                for (int kw = 0; kw < dec_cfg_pkg::KSIZE; kw++) begin
                    ih = h + kh - 1;
                    iw = w + kw - 1;
                    // Zero padding outside the 8x8 map
                    if (ih >= 0 && ih < dec_cfg_pkg::UP_H && iw >= 0 && iw < dec_cfg_pkg::UP_W) begin
                        if (ic < dec_cfg_pkg::IN_CH) begin
                            f = int'(in_mem[((ih / 2) * dec_cfg_pkg::IN_W + iw / 2)
                                            * dec_cfg_pkg::IN_CH + ic]);
                        end else begin
                            f = int'(skip_mem[(ih * dec_cfg_pkg::UP_W + iw) * dec_cfg_pkg::SKIP_CH
                                              + ic - dec_cfg_pkg::IN_CH]);
                        end
                        acc += f * int'(wgt_mem[(ic * dec_cfg_pkg::KTAPS + kh * dec_cfg_pkg::KSIZE
                                                 + kw) * dec_cfg_pkg::OUT_CH + oc]);
                    end
                end
            end
        end
        return (acc < 0) ? 16'h0000 : acc[15:0];
    endfunction

    task automatic compare(input logic [15:0] got, input logic [15:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input logic [15:0] s);
        if (!running) begin
            compare(s, {14'h0, done_m, 1'b0}, "idle status");
        end else if (await_busy) begin
            // New run: busy up, done cleared
            compare(s, 16'h0001, "status after start");
            await_busy = 1'b0;
        end else if (s[dec_bus_pkg::STAT_DONE]) begin
            compare(s, 16'h0002, "status at done");
            running = 1'b0;
            done_m  = 1'b1;
        end else begin
            compare(s, 16'h0001, "status while running");
        end
    endtask

    always @(posedge clk) begin
        int ofs;
        if (rst) begin
            checks     = 0;
            errors     = 0;
            running    = 1'b0;
            done_m     = 1'b0;
            await_busy = 1'b0;
        end else if (wb_rsp.ack) begin
            ofs = int'(wb_req.adr);
            if (wb_req.we) begin
                if (in_window(ofs, dec_bus_pkg::IN_BASE, dec_cfg_pkg::IN_WORDS)) begin
                    in_mem[ofs - int'(dec_bus_pkg::IN_BASE)] = wb_req.dat_w;
                end
                if (in_window(ofs, dec_bus_pkg::SKIP_BASE, dec_cfg_pkg::SKIP_WORDS)) begin
                    skip_mem[ofs - int'(dec_bus_pkg::SKIP_BASE)] = wb_req.dat_w;
                end
                if (in_window(ofs, dec_bus_pkg::WGT_BASE, dec_cfg_pkg::WGT_WORDS)) begin
                    wgt_mem[ofs - int'(dec_bus_pkg::WGT_BASE)] = wb_req.dat_w[7:0];
                end
                // Start only counts when no run is in progress
                if (wb_req.adr == dec_bus_pkg::ADR_CTRL &&
                    wb_req.dat_w[dec_bus_pkg::CTRL_START] && !running) begin
                    running    = 1'b1;
                    done_m     = 1'b0;
                    await_busy = 1'b1;
                end
            end else if (wb_req.adr == dec_bus_pkg::ADR_STATUS) begin
                check_status(wb_rsp.dat_r);
            end else if (in_window(ofs, dec_bus_pkg::OUT_BASE, dec_cfg_pkg::OUT_WORDS)) begin
                compare(wb_rsp.dat_r, expected_out(ofs - int'(dec_bus_pkg::OUT_BASE)),
                        $sformatf("output word %0d", ofs - int'(dec_bus_pkg::OUT_BASE)));
            end else begin
                compare(wb_rsp.dat_r, 16'h0000, $sformatf("word at 0x%03h", ofs));
            end
        end
    end

endmodule

// File: tb/unet_dec_props.sv
/* Wishbone and status assertions */
`timescale 1ns/1ps

module unet_dec_props (
    input logic                 clk,
    input logic                 rst,
    input dec_bus_pkg::wb_req_t wb_req,
    input dec_bus_pkg::wb_rsp_t wb_rsp,
    input logic                 busy,
    input logic                 go
);

    int   fail_count = 0;
    logic req;

    assign req = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    // Registered ack, one cycle after a new request
    ack_follows_req: assert property (@(posedge clk) disable iff (rst) req |=> wb_rsp.ack)
        else begin
            fail_count++;
            $error("ack missing one cycle after a request");
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fail_count++;
            $error("ack held for two cycles");
        end

    // Host still holds the strobe while ack is up
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
        else begin
            fail_count++;
            $error("ack outside a bus cycle");
        end

    // Engine takes the run the cycle after start
    go_starts_run: assert property (@(posedge clk) disable iff (rst) go |=> busy)
        else begin
            fail_count++;
            $error("start did not raise busy");
        end

endmodule

bind dec_regs unet_dec_props props0 (
    .clk(clk),
    .rst(rst),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp),
    .busy(busy),
    .go(go)
);

// File: logic/unet_dec_top.sv
/* U-Net decoder stage top */
`timescale 1ns/1ps

module unet_dec_top (
    input  logic                 clk,
    input  logic                 rst,
    input  dec_bus_pkg::wb_req_t wb_req,
    output dec_bus_pkg::wb_rsp_t wb_rsp
);

    // Host side memory ports
    logic                           in_we;
    logic [dec_cfg_pkg::IN_AW-1:0]  in_waddr;
    dec_cfg_pkg::feat_t             in_wdata;
    logic                           skip_we;
    logic [dec_cfg_pkg::MAP_AW-1:0] skip_waddr;
    dec_cfg_pkg::feat_t             skip_wdata;
    logic                           wgt_we;
    logic [dec_cfg_pkg::WGT_AW-1:0] wgt_waddr;
    dec_cfg_pkg::wgt_t              wgt_wdata;
    logic [dec_cfg_pkg::MAP_AW-1:0] out_raddr;
    dec_cfg_pkg::feat_t             out_rdata;
    logic                           busy;
    logic                           fin;
    logic                           go;

    // Engine side
    logic [dec_cfg_pkg::POS_W-1:0]  row;
    logic [dec_cfg_pkg::POS_W-1:0]  col;
    logic [dec_cfg_pkg::CH_W-1:0]   ic;
    logic [dec_cfg_pkg::K_W-1:0]    kh;
    logic [dec_cfg_pkg::K_W-1:0]    kw;
    logic [dec_cfg_pkg::MAP_AW-1:0] tap_addr;
    logic                           use_skip;
    logic                           pad;
    logic [dec_cfg_pkg::MAP_AW-1:0] feat_raddr;
    dec_cfg_pkg::feat_t             in_rdata;
    dec_cfg_pkg::feat_t             skip_rdata;
    logic [dec_cfg_pkg::WGT_AW-1:0] wgt_raddr;
    dec_cfg_pkg::wgt_t              wgt_rdata;
    logic                           out_we;
    logic [dec_cfg_pkg::MAP_AW-1:0] out_waddr;
    dec_cfg_pkg::feat_t             out_wdata;

    dec_regs u_regs (.*);

    feature_ram #(.entry_t(dec_cfg_pkg::feat_t), .DEPTH(dec_cfg_pkg::IN_WORDS)) in_ram (
        .clk(clk), .we(in_we), .waddr(in_waddr), .wdata(in_wdata),
        .raddr(feat_raddr[dec_cfg_pkg::IN_AW-1:0]), .rdata(in_rdata)
    );

    feature_ram #(.entry_t(dec_cfg_pkg::feat_t), .DEPTH(dec_cfg_pkg::SKIP_WORDS)) skip_ram (
        .clk(clk), .we(skip_we), .waddr(skip_waddr), .wdata(skip_wdata),
        .raddr(feat_raddr), .rdata(skip_rdata)
    );

    feature_ram #(.entry_t(dec_cfg_pkg::wgt_t), .DEPTH(dec_cfg_pkg::WGT_WORDS)) wgt_ram (
        .clk(clk), .we(wgt_we), .waddr(wgt_waddr), .wdata(wgt_wdata),
        .raddr(wgt_raddr), .rdata(wgt_rdata)
    );

    // Engine writes, host reads back
    feature_ram #(.entry_t(dec_cfg_pkg::feat_t), .DEPTH(dec_cfg_pkg::OUT_WORDS)) out_ram (
        .clk(clk), .we(out_we), .waddr(out_waddr), .wdata(out_wdata),
        .raddr(out_raddr), .rdata(out_rdata)
    );

    tap_fetch u_tap (.addr(tap_addr), .*);

    conv_engine u_engine (.*);

endmodule

// File: logic/dec_regs.sv
/* Wishbone register and memory decode */
`timescale 1ns/1ps

module dec_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  dec_bus_pkg::wb_req_t           wb_req,
    output dec_bus_pkg::wb_rsp_t           wb_rsp,
    output logic                           in_we,
    output logic [dec_cfg_pkg::IN_AW-1:0]  in_waddr,
    output dec_cfg_pkg::feat_t             in_wdata,
    output logic                           skip_we,
    output logic [dec_cfg_pkg::MAP_AW-1:0] skip_waddr,
    output dec_cfg_pkg::feat_t             skip_wdata,
    output logic                           wgt_we,
    output logic [dec_cfg_pkg::WGT_AW-1:0] wgt_waddr,
    output dec_cfg_pkg::wgt_t              wgt_wdata,
    output logic [dec_cfg_pkg::MAP_AW-1:0] out_raddr,
    input  dec_cfg_pkg::feat_t             out_rdata,
    input  logic                           busy,
    input  logic                           fin,
    output logic                           go
);

    logic ack;
    logic req;
    logic wr;
    logic hit_ctrl;
    logic hit_stat;
    logic hit_in;
    logic hit_skip;
    logic hit_wgt;
    logic hit_out;
    logic done;
    logic rd_out;
    logic [dec_bus_pkg::DAT_W-1:0] rd_data;

    // New access only while no ack is pending
    assign req = wb_req.cyc && wb_req.stb && !ack;
    assign wr  = req && wb_req.we;

    assign hit_ctrl = wb_req.adr == dec_bus_pkg::ADR_CTRL;
    assign hit_stat = wb_req.adr == dec_bus_pkg::ADR_STATUS;
    assign hit_in   = wb_req.adr >= dec_bus_pkg::IN_BASE &&
                      wb_req.adr < dec_bus_pkg::IN_BASE + dec_cfg_pkg::IN_WORDS;
    assign hit_skip = wb_req.adr >= dec_bus_pkg::SKIP_BASE &&
                      wb_req.adr < dec_bus_pkg::SKIP_BASE + dec_cfg_pkg::SKIP_WORDS;
    assign hit_wgt  = wb_req.adr >= dec_bus_pkg::WGT_BASE &&
                      wb_req.adr < dec_bus_pkg::WGT_BASE + dec_cfg_pkg::WGT_WORDS;
    assign hit_out  = wb_req.adr >= dec_bus_pkg::OUT_BASE &&
                      wb_req.adr < dec_bus_pkg::OUT_BASE + dec_cfg_pkg::OUT_WORDS;

    // One-cycle write strobes
    assign in_we   = wr && hit_in;
    assign skip_we = wr && hit_skip;
    assign wgt_we  = wr && hit_wgt;

    // Low address bits index each window
    assign in_waddr   = wb_req.adr[dec_cfg_pkg::IN_AW-1:0];
    assign skip_waddr = wb_req.adr[dec_cfg_pkg::MAP_AW-1:0];
    assign wgt_waddr  = wb_req.adr[dec_cfg_pkg::WGT_AW-1:0];
    assign out_raddr  = wb_req.adr[dec_cfg_pkg::MAP_AW-1:0];
    assign in_wdata   = wb_req.dat_w;
    assign skip_wdata = wb_req.dat_w;
    // Weights and biases in the low byte
    assign wgt_wdata  = wb_req.dat_w[$bits(dec_cfg_pkg::wgt_t)-1:0];

    // Start is dropped while a run is in progress
    assign go = wr && hit_ctrl && wb_req.dat_w[dec_bus_pkg::CTRL_START] && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack    <= 1'b0;
            done   <= 1'b0;
            rd_out <= 1'b0;
        end else begin
            ack <= req;
            if (go) begin
                done <= 1'b0;
            end else if (fin) begin
                done <= 1'b1;
            end
            if (req) begin
                rd_out <= hit_out && !wb_req.we;
            end
        end
    end

    // Status snapshot, presented with ack
    always_ff @(posedge clk) begin
        if (req) begin
            rd_data <= '0;
            if (hit_stat) begin
                rd_data[dec_bus_pkg::STAT_BUSY] <= busy;
                rd_data[dec_bus_pkg::STAT_DONE] <= done;
            end
        end
    end

    assign wb_rsp.ack   = ack;
    // Output memory read lands in the ack cycle
    assign wb_rsp.dat_r = rd_out ? out_rdata : rd_data;

endmodule

// File: logic/conv_engine.sv
/* 3x3 convolution engine with bias and ReLU */
`timescale 1ns/1ps

module conv_engine (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           go,
    output logic                           busy,
    output logic                           fin,
    output logic [dec_cfg_pkg::POS_W-1:0]  row,
    output logic [dec_cfg_pkg::POS_W-1:0]  col,
    output logic [dec_cfg_pkg::CH_W-1:0]   ic,
    output logic [dec_cfg_pkg::K_W-1:0]    kh,
    output logic [dec_cfg_pkg::K_W-1:0]    kw,
    input  logic [dec_cfg_pkg::MAP_AW-1:0] tap_addr,
    input  logic                           use_skip,
    input  logic                           pad,
    output logic [dec_cfg_pkg::MAP_AW-1:0] feat_raddr,
    input  dec_cfg_pkg::feat_t             in_rdata,
    input  dec_cfg_pkg::feat_t             skip_rdata,
    output logic [dec_cfg_pkg::WGT_AW-1:0] wgt_raddr,
    input  dec_cfg_pkg::wgt_t              wgt_rdata,
    output logic                           out_we,
    output logic [dec_cfg_pkg::MAP_AW-1:0] out_waddr,
    output dec_cfg_pkg::feat_t             out_wdata
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BIAS,
        ST_SCAN,
        ST_DRAIN,
        ST_WRITE
    } state_t;

    state_t state;
    logic [dec_cfg_pkg::OC_W-1:0] oc;
    logic last_tap;
    logic last_pix;
    logic bias_v;
    logic rd_v;
    logic mac_v;
    logic rd_pad;
    logic rd_skip;
    dec_cfg_pkg::feat_t f_op;
    dec_cfg_pkg::wgt_t  w_op;
    dec_cfg_pkg::acc_t  acc;

    assign last_tap = int'(ic) == dec_cfg_pkg::CAT_CH - 1 &&
                      int'(kh) == dec_cfg_pkg::KSIZE - 1 &&
                      int'(kw) == dec_cfg_pkg::KSIZE - 1;
    assign last_pix = int'(oc) == dec_cfg_pkg::OUT_CH - 1 &&
                      int'(row) == dec_cfg_pkg::UP_H - 1 &&
                      int'(col) == dec_cfg_pkg::UP_W - 1;

    always_comb begin
        int w_idx;
        int o_idx;
        w_idx = ((int'(ic) * dec_cfg_pkg::KTAPS + int'(kh) * dec_cfg_pkg::KSIZE + int'(kw))
                 * dec_cfg_pkg::OUT_CH) + int'(oc);
        // Bias word fetched ahead of the pixel's first tap
        if (state == ST_BIAS) begin
            w_idx = dec_cfg_pkg::BIAS_BASE + int'(oc);
        end
        o_idx = (int'(oc) * dec_cfg_pkg::UP_H + int'(row)) * dec_cfg_pkg::UP_W + int'(col);
        wgt_raddr = w_idx[dec_cfg_pkg::WGT_AW-1:0];
        out_waddr = o_idx[dec_cfg_pkg::MAP_AW-1:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            oc     <= '0;
            row    <= '0;
            col    <= '0;
            ic     <= '0;
            kh     <= '0;
            kw     <= '0;
            bias_v <= 1'b0;
            rd_v   <= 1'b0;
            mac_v  <= 1'b0;
        end else begin
            bias_v <= state == ST_BIAS;
            rd_v   <= state == ST_SCAN;
            mac_v  <= rd_v;
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        state <= ST_BIAS;
                    end
                end
                ST_BIAS: begin
                    state <= ST_SCAN;
                end
                ST_SCAN: begin
                    // kw fastest, then kh, then concat channel
                    kw <= kw + 1'b1;
                    if (int'(kw) == dec_cfg_pkg::KSIZE - 1) begin
                        kw <= '0;
                        kh <= kh + 1'b1;
                        if (int'(kh) == dec_cfg_pkg::KSIZE - 1) begin
                            kh <= '0;
                            ic <= ic + 1'b1;
                        end
                    end
                    if (last_tap) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    // Last tap reaches the accumulator in this cycle
                    if (!rd_v) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    col <= col + 1'b1;
                    if (int'(col) == dec_cfg_pkg::UP_W - 1) begin
                        row <= row + 1'b1;
                        if (int'(row) == dec_cfg_pkg::UP_H - 1) begin
                            oc <= oc + 1'b1;
                        end
                    end
                    state <= last_pix ? ST_IDLE : ST_BIAS;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Two-stage datapath: operand capture, then accumulate
    always_ff @(posedge clk) begin
        rd_pad  <= pad;
        rd_skip <= use_skip;
        if (rd_pad) begin
            f_op <= '0;
        end else begin
            f_op <= rd_skip ? skip_rdata : in_rdata;
        end
        w_op <= wgt_rdata;
        if (bias_v) begin
            acc <= wgt_rdata;
        end else if (mac_v) begin
            acc <= acc + f_op * w_op;
        end
    end

    assign feat_raddr = tap_addr;
    assign busy       = state != ST_IDLE;
    assign out_we     = state == ST_WRITE;
    assign fin        = out_we && last_pix;
    // ReLU, low half of a non-negative sum
    assign out_wdata  = (acc < 0) ? '0 : acc[15:0];

endmodule

// File: logic/tap_fetch.sv
/* Convolution tap address mapping */
`timescale 1ns/1ps

module tap_fetch (
    input  logic [dec_cfg_pkg::POS_W-1:0]  row,
    input  logic [dec_cfg_pkg::POS_W-1:0]  col,
    input  logic [dec_cfg_pkg::CH_W-1:0]   ic,
    input  logic [dec_cfg_pkg::K_W-1:0]    kh,
    input  logic [dec_cfg_pkg::K_W-1:0]    kw,
    output logic [dec_cfg_pkg::MAP_AW-1:0] addr,
    output logic                           use_skip,
    output logic                           pad
);

    always_comb begin
        int ih;
        int iw;
        int idx;
        // Kernel centre sits on the output pixel
        ih = int'(row) + int'(kh) - dec_cfg_pkg::KSIZE / 2;
        iw = int'(col) + int'(kw) - dec_cfg_pkg::KSIZE / 2;
        pad = ih < 0 || ih >= dec_cfg_pkg::UP_H ||
              iw < 0 || iw >= dec_cfg_pkg::UP_W;

        // Concat order: upsampled channels, then skip channels
        use_skip = int'(ic) >= dec_cfg_pkg::IN_CH;
        if (use_skip) begin
            idx = (ih * dec_cfg_pkg::UP_W + iw) * dec_cfg_pkg::SKIP_CH
                  + int'(ic) - dec_cfg_pkg::IN_CH;
        end else begin
            // Nearest neighbour, one input pixel per 2x2 block
            idx = ((ih >>> 1) * dec_cfg_pkg::IN_W + (iw >>> 1)) * dec_cfg_pkg::IN_CH
                  + int'(ic);
        end
        // Address is don't-care on padded taps
        addr = idx[dec_cfg_pkg::MAP_AW-1:0];
    end

endmodule

// File: logic/feature_ram.sv
/* Registered-read memory */
`timescale 1ns/1ps

module feature_ram #(
    parameter type entry_t = logic [15:0],
    parameter int  DEPTH   = 32
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // Data follows the address by one cycle
        rdata <= mem[raddr];
    end

endmodule

// File: logic/dec_bus_pkg.sv
/* Host bus types and register map */
package dec_bus_pkg;

    localparam int ADR_W = 9;
    localparam int DAT_W = 16;

    // Wishbone classic, host to slave
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] dat_w;
    } wb_req_t;

    // Slave to host
    typedef struct packed {
        logic             ack;
        logic [DAT_W-1:0] dat_r;
    } wb_rsp_t;

    // Control and status words
    localparam logic [ADR_W-1:0] ADR_CTRL   = 9'h000;
    localparam logic [ADR_W-1:0] ADR_STATUS = 9'h001;

    localparam int CTRL_START = 0;
    localparam int STAT_BUSY  = 0;
    localparam int STAT_DONE  = 1;

    // Memory windows, each aligned to a power of two at least its depth
    localparam logic [ADR_W-1:0] IN_BASE   = 9'h040;
    localparam logic [ADR_W-1:0] SKIP_BASE = 9'h080;
    localparam logic [ADR_W-1:0] WGT_BASE  = 9'h100;
    localparam logic [ADR_W-1:0] OUT_BASE  = 9'h180;

endpackage

// File: logic/dec_cfg_pkg.sv
/* Decoder stage geometry and data types */
package dec_cfg_pkg;

    // Input map, upsampled by two to the output size
    localparam int IN_W = 4;
    localparam int IN_H = 4;
    localparam int UP_W = 2 * IN_W;
    localparam int UP_H = 2 * IN_H;

    localparam int IN_CH   = 2;
    localparam int SKIP_CH = 2;
    localparam int CAT_CH  = IN_CH + SKIP_CH;
    localparam int OUT_CH  = 2;

    localparam int KSIZE = 3;
    localparam int KTAPS = KSIZE * KSIZE;

    // Memory depths in words
    localparam int IN_WORDS   = IN_W * IN_H * IN_CH;
    localparam int SKIP_WORDS = UP_W * UP_H * SKIP_CH;
    localparam int OUT_WORDS  = UP_W * UP_H * OUT_CH;
    // Kernel weights first, then one bias per output channel
    localparam int BIAS_BASE  = CAT_CH * KTAPS * OUT_CH;
    localparam int WGT_WORDS  = BIAS_BASE + OUT_CH;

    // Address and counter widths
    localparam int IN_AW  = $clog2(IN_WORDS);
    localparam int MAP_AW = $clog2(SKIP_WORDS);
    localparam int WGT_AW = $clog2(WGT_WORDS);
    localparam int POS_W  = $clog2(UP_W);
    localparam int CH_W   = $clog2(CAT_CH);
    localparam int K_W    = $clog2(KSIZE);
    localparam int OC_W   = $clog2(OUT_CH);

    typedef logic signed [15:0] feat_t;
    typedef logic signed [7:0]  wgt_t;
    typedef logic signed [31:0] acc_t;

endpackage
